/* hw/aexm_config.svh */
`ifndef AEXM_CONFIG_SVH
`define AEXM_CONFIG_SVH

// Datapath word width
`define AEXM_DATA_WIDTH 32

// General purpose registers, r0 reads as zero
`define AEXM_REG_COUNT 32

`define AEXM_DMEM_AW 8  // Data RAM word-address bits

`endif

/* hw/aexmPkg.sv */
`include "aexm_config.svh"

package aexmPkg;

  typedef logic [`AEXM_DATA_WIDTH-1:0]         word_t;
  typedef logic [$clog2(`AEXM_REG_COUNT)-1:0]  regAddr_t;
  typedef logic [5:0]                          opcode_t;
  typedef logic [15:0]                         imm_t;
  typedef logic [1:0]                          srcSel_t;
  typedef logic [2:0]                          aluSel_t;
  typedef logic [1:0]                          dstSel_t;

  // Operand source, resolved in the execute stage
  localparam srcSel_t SRC_REG  = 2'd0;
  localparam srcSel_t SRC_FWD  = 2'd1;  // Instruction just ahead, ALU or load
  localparam srcSel_t SRC_LATE = 2'd2;  // Instruction two ahead
  localparam srcSel_t SRC_IMM  = 2'd3;

  localparam aluSel_t ALU_ADD   = 3'd0;
  localparam aluSel_t ALU_RSUB  = 3'd1;
  localparam aluSel_t ALU_OR    = 3'd2;
  localparam aluSel_t ALU_SHIFT = 3'd3;
  localparam aluSel_t ALU_AND   = 3'd4;
  localparam aluSel_t ALU_XOR   = 3'd5;
  localparam aluSel_t ALU_STORE = 3'd6;  // Address add plus RAM write

  localparam dstSel_t DST_ALU  = 2'd0;
  localparam dstSel_t DST_LOAD = 2'd2;
  localparam dstSel_t DST_NONE = 2'd3;

  // Register forms, bit 3 set gives the immediate form
  localparam opcode_t ADD   = 6'o00;
  localparam opcode_t RSUB  = 6'o01;
  localparam opcode_t OR    = 6'o40;
  localparam opcode_t AND   = 6'o41;
  localparam opcode_t XOR   = 6'o42;
  localparam opcode_t SHIFT = 6'o44;
  localparam opcode_t LW    = 6'o62;
  localparam opcode_t SW    = 6'o66;

endpackage

/* hw/aexmDecodeCtrl.sv */
`timescale 1ns/1ps
`include "aexm_config.svh"

module aexmDecodeCtrl (
  input  logic               gclk,
  input  logic               grst,
  input  logic               instValid,
  input  aexmPkg::word_t     instWord,
  input  logic               wbValid,
  input  aexmPkg::regAddr_t  wbReg,
  output aexmPkg::regAddr_t  rdAddrA,
  output aexmPkg::regAddr_t  rdAddrB,
  output aexmPkg::regAddr_t  rdAddrD,
  output aexmPkg::srcSel_t   xSrcA,
  output aexmPkg::srcSel_t   xSrcB,
  output aexmPkg::srcSel_t   xSrcD,
  output aexmPkg::aluSel_t   xAlu,
  output aexmPkg::dstSel_t   xDst,
  output aexmPkg::regAddr_t  xRw,
  output aexmPkg::word_t     xImm,
  output logic               xValid
);
  import aexmPkg::*;

  opcode_t  opc;
  opcode_t  opBase;
  regAddr_t rd;
  regAddr_t ra;
  regAddr_t rb;
  imm_t     imm;
  logic     isImm;
  logic     isAlu;
  logic     isLoad;
  aluSel_t  aluNext;
  dstSel_t  dstNext;
  srcSel_t  srcANext;
  srcSel_t  srcBNext;
  srcSel_t  srcDNext;

  assign {opc, rd, ra, rb} = instWord[31:11];
  assign imm    = instWord[15:0];
  assign isImm  = opc[3];
  assign opBase = {opc[5:4], 1'b0, opc[2:0]};  // Fold both forms together

  assign rdAddrA = ra;
  assign rdAddrB = rb;
  assign rdAddrD = rd;  // Store data

  // Newest producer wins and bubbles never match
  function automatic srcSel_t pickSrc(input regAddr_t r);
    if (xValid && (xDst != DST_NONE) && (xRw == r))
      return SRC_FWD;
    else if (wbValid && (wbReg == r))
      return SRC_LATE;
    else
      return SRC_REG;
  endfunction

  always_comb begin
    aluNext = ALU_ADD;
    isAlu   = 1'b0;
    isLoad  = 1'b0;
    case (opBase)
      ADD:     isAlu = 1'b1;
      RSUB: begin
        isAlu   = 1'b1;
        aluNext = ALU_RSUB;
      end
      OR: begin
        isAlu   = 1'b1;
        aluNext = ALU_OR;
      end
      AND: begin
        isAlu   = 1'b1;
        aluNext = ALU_AND;
      end
      XOR: begin
        isAlu   = 1'b1;
        aluNext = ALU_XOR;
      end
      SHIFT: begin
        isAlu   = !isImm;  // 6'o54 is not a shift
        aluNext = ALU_SHIFT;
      end
      LW:      isLoad = 1'b1;
      SW:      aluNext = ALU_STORE;
      default: ;  // Unknown opcode acts as a no-op
    endcase
    dstNext  = (!(isAlu || isLoad) || (rd == '0)) ? DST_NONE :
               isLoad ? DST_LOAD : DST_ALU;
    srcANext = pickSrc(ra);
    srcBNext = isImm ? SRC_IMM : pickSrc(rb);
    srcDNext = pickSrc(rd);
  end

  always_ff @(posedge gclk) begin
    if (grst) begin
      xValid <= 1'b0;
      xDst   <= DST_NONE;
    end else begin
      xValid <= instValid;
      xDst   <= instValid ? dstNext : DST_NONE;  // Bubble writes nothing
    end
  end

  always_ff @(posedge gclk) begin
    xSrcA <= srcANext;
    xSrcB <= srcBNext;
    xSrcD <= srcDNext;
    xAlu  <= aluNext;
    xRw   <= rd;
    xImm  <= {{(`AEXM_DATA_WIDTH-16){imm[15]}}, imm};
  end

  // Caller strobe known and a valid word fully defined
  assert property (@(posedge gclk) disable iff (grst) !$isunknown(instValid));
  assert property (@(posedge gclk) disable iff (grst) instValid |-> !$isunknown(instWord));

endmodule

/* hw/aexmRegFile.sv */
`timescale 1ns/1ps
`include "aexm_config.svh"

module aexmRegFile (
  input  logic               gclk,
  input  aexmPkg::regAddr_t  rdAddrA,
  input  aexmPkg::regAddr_t  rdAddrB,
  input  aexmPkg::regAddr_t  rdAddrD,
  input  logic               wrEn,
  input  aexmPkg::regAddr_t  wrAddr,
  input  aexmPkg::word_t     wrData,
  output aexmPkg::word_t     rdDataA,
  output aexmPkg::word_t     rdDataB,
  output aexmPkg::word_t     rdDataD
);
  import aexmPkg::*;

  word_t regs [`AEXM_REG_COUNT];

  // Combinational reads, r0 forced to zero
  assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
  assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];
  assign rdDataD = (rdAddrD == '0) ? '0 : regs[rdAddrD];

  // Same-cycle read of a register being written returns the old value
  always_ff @(posedge gclk) begin
    if (wrEn)
      regs[wrAddr] <= wrData;
  end

  // Decode maps rd of zero to no destination
  assert property (@(posedge gclk) wrEn |-> (wrAddr != '0));

endmodule

/* hw/aexmOperandStage.sv */
`timescale 1ns/1ps

module aexmOperandStage (
  input  logic              gclk,
  input  aexmPkg::word_t    rdDataA,
  input  aexmPkg::word_t    rdDataB,
  input  aexmPkg::word_t    rdDataD,
  input  aexmPkg::word_t    xImm,
  input  aexmPkg::word_t    exResult,
  input  aexmPkg::word_t    wbData,
  input  aexmPkg::word_t    memRdData,
  input  aexmPkg::srcSel_t  xSrcA,
  input  aexmPkg::srcSel_t  xSrcB,
  input  aexmPkg::srcSel_t  xSrcD,
  input  aexmPkg::dstSel_t  xDst,
  input  aexmPkg::dstSel_t  lastDst,
  output aexmPkg::word_t    opA,
  output aexmPkg::word_t    opB,
  output aexmPkg::word_t    opD
);
  import aexmPkg::*;

  word_t regA;
  word_t regB;
  word_t regD;
  word_t fwdVal;   // ALU result of the instruction just ahead
  word_t lateVal;  // Writeback value of the instruction two ahead
  word_t aheadVal;

  always_ff @(posedge gclk) begin
    regA    <= rdDataA;
    regB    <= rdDataB;
    regD    <= rdDataD;
    fwdVal  <= exResult;
    lateVal <= wbData;
  end

  // A load just ahead has its RAM data arriving this cycle
  assign aheadVal = (lastDst == DST_LOAD) ? memRdData : fwdVal;

  function automatic word_t pick(input srcSel_t sel, input word_t regVal);
    case (sel)
      SRC_FWD:  return aheadVal;
      SRC_LATE: return lateVal;
      SRC_IMM:  return xImm;
      default:  return regVal;
    endcase
  endfunction

  always_comb begin
    opA = pick(xSrcA, regA);
    opB = pick(xSrcB, regB);
    opD = (xDst == DST_NONE) ? pick(xSrcD, regD) : '0;  // Only stores use D
  end

endmodule

/* hw/aexmExecStage.sv */
`timescale 1ns/1ps
`include "aexm_config.svh"

module aexmExecStage (
  input  logic               gclk,
  input  logic               grst,
  input  aexmPkg::word_t     opA,
  input  aexmPkg::word_t     opB,
  input  aexmPkg::word_t     opD,
  input  aexmPkg::aluSel_t   xAlu,
  input  aexmPkg::dstSel_t   xDst,
  input  aexmPkg::regAddr_t  xRw,
  input  aexmPkg::word_t     xImm,
  input  logic               xValid,
  input  aexmPkg::word_t     memRdData,
  output aexmPkg::word_t     exResult,
  output aexmPkg::word_t     memAddr,
  output aexmPkg::word_t     memWrData,
  output logic               memWe,
  output logic               wbValid,
  output aexmPkg::regAddr_t  wbReg,
  output aexmPkg::word_t     wbData,
  output aexmPkg::dstSel_t   lastDst
);
  import aexmPkg::*;

  localparam int MSB = `AEXM_DATA_WIDTH - 1;

  word_t wbAlu;

  always_comb begin
    case (xAlu)
      ALU_RSUB:  exResult = opB - opA;
      ALU_OR:    exResult = opA | opB;
      ALU_AND:   exResult = opA & opB;
      ALU_XOR:   exResult = opA ^ opB;
      // Function field bit 6 picks srl over sra
      ALU_SHIFT: exResult = {(xImm[6] ? 1'b0 : opA[MSB]), opA[MSB:1]};
      default:   exResult = opA + opB;
    endcase
  end

  // Byte address, the RAM drops the low two bits
  assign memAddr   = opA + opB;
  assign memWrData = opD;
  assign memWe     = xValid && (xAlu == ALU_STORE);

  always_ff @(posedge gclk) begin
    if (grst) begin
      wbValid <= 1'b0;
      lastDst <= DST_NONE;
    end else begin
      wbValid <= xValid && (xDst != DST_NONE);
      lastDst <= xDst;
    end
  end

  always_ff @(posedge gclk) begin
    wbReg <= xRw;
    wbAlu <= exResult;
  end

  assign wbData = (lastDst == DST_LOAD) ? memRdData : wbAlu;  // Load data lands now

  assert property (@(posedge gclk) disable iff (grst) wbValid |-> !$isunknown(wbData));

endmodule

/* hw/aexmDataMem.sv */
`timescale 1ns/1ps
`include "aexm_config.svh"

module aexmDataMem (
  input  logic            gclk,
  input  aexmPkg::word_t  memAddr,
  input  logic            memWe,
  input  aexmPkg::word_t  memWrData,
  output aexmPkg::word_t  memRdData
);
  import aexmPkg::*;

  localparam int DEPTH = 1 << `AEXM_DMEM_AW;

  word_t ram [DEPTH];
  logic [`AEXM_DMEM_AW-1:0] wordIdx;

  assign wordIdx = memAddr[`AEXM_DMEM_AW+1:2];

  // Single port, a write cycle leaves the read data unchanged
  always_ff @(posedge gclk) begin
    if (memWe)
      ram[wordIdx] <= memWrData;
    else
      memRdData <= ram[wordIdx];
  end

endmodule

/* hw/aexmCore.sv */
`timescale 1ns/1ps

module aexmCore (
  input  logic               gclk,
  input  logic               grst,
  input  logic               instValid,
  input  aexmPkg::word_t     instWord,
  output logic               wbValid,
  output aexmPkg::regAddr_t  wbReg,
  output aexmPkg::word_t     wbData
);
  import aexmPkg::*;

  regAddr_t rdAddrA, rdAddrB, rdAddrD;
  word_t    rdDataA, rdDataB, rdDataD;
  srcSel_t  xSrcA, xSrcB, xSrcD;
  aluSel_t  xAlu;
  dstSel_t  xDst;
  regAddr_t xRw;
  word_t    xImm;
  logic     xValid;
  word_t    opA, opB, opD;
  word_t    exResult;
  dstSel_t  lastDst;
  word_t    memAddr, memWrData, memRdData;
  logic     memWe;

  aexmDecodeCtrl decodeCtrl (.*);

  // Write port fed straight from the writeback register
  aexmRegFile regFile (
    .gclk    (gclk),
    .rdAddrA (rdAddrA),
    .rdAddrB (rdAddrB),
    .rdAddrD (rdAddrD),
    .wrEn    (wbValid),
    .wrAddr  (wbReg),
    .wrData  (wbData),
    .rdDataA (rdDataA),
    .rdDataB (rdDataB),
    .rdDataD (rdDataD)
  );

  aexmOperandStage operandStage (.*);

  aexmExecStage execStage (.*);

  aexmDataMem dataMem (.*);

endmodule

/* testbench/aexmCoreTb.sv */
`timescale 1ns/1ps
`include "aexm_config.svh"

module aexmCoreTb;
  import aexmPkg::*;

  localparam int NUM_RANDOM = 300;
  // Init 62, mem fill 16, chains 25, mid-reset 23
  localparam int TOTAL_INSTR = 62 + 16 + 25 + NUM_RANDOM + 23;
  localparam int CYCLE_LIMIT = 4 * (TOTAL_INSTR + 20);

  logic     gclk;
  logic     grst;
  logic     instValid;
  word_t    instWord;
  logic     wbValid;
  regAddr_t wbReg;
  word_t    wbData;

  word_t       modelRegs [`AEXM_REG_COUNT];
  word_t       modelMem [1 << `AEXM_DMEM_AW];
  logic [36:0] expQ [$];  // {reg, value}
  int          errors = 0;
  int          cycles = 0;
  string       testName = "reset";

  aexmCore uut (.*);

  initial begin
    gclk = 1'b0;
    forever #5 gclk = ~gclk;
  end

  function automatic word_t encR(opcode_t op, int rd, int ra, int rb, int fn);
    return {op, 5'(rd), 5'(ra), 5'(rb), 11'(fn)};
  endfunction

  function automatic word_t encI(opcode_t op, int rd, int ra, int imm);
    return {op | 6'o10, 5'(rd), 5'(ra), 16'(imm)};
  endfunction

  // ISA model run at issue time in program order
  function automatic void refExec(word_t inst);
    opcode_t  op;
    regAddr_t rd;
    word_t    a;
    word_t    b;
    word_t    addr;
    word_t    res;
    logic     writes;
    op   = {inst[31:30], 1'b0, inst[28:26]};  // Immediate bit cleared
    rd   = inst[25:21];
    a    = modelRegs[inst[20:16]];
    b    = inst[29] ? {{16{inst[15]}}, inst[15:0]} : modelRegs[inst[15:11]];
    addr = a + b;
    res    = '0;
    writes = 1'b1;
    case (op)
      ADD:   res = a + b;
      RSUB:  res = b - a;
      OR:    res = a | b;
      AND:   res = a & b;
      XOR:   res = a ^ b;
      SHIFT: begin
        writes = !inst[29];  // No immediate shift
        res    = {inst[6] ? 1'b0 : a[31], a[31:1]};
      end
      LW:    res = modelMem[addr[9:2]];
      SW: begin
        writes = 1'b0;
        modelMem[addr[9:2]] = modelRegs[rd];
      end
      default: writes = 1'b0;
    endcase
    if (writes && rd != 0) begin
      modelRegs[rd] = res;
      expQ.push_back({rd, res});
    end
  endfunction

  function automatic word_t randomInst();
    int rd;
    int ra;
    int rb;
    rd = $urandom % 8;
    ra = $urandom % 8;
    rb = $urandom % 8;
    case ($urandom % 15)
      0:  return encR(ADD, rd, ra, rb, 0);
      1:  return encR(RSUB, rd, ra, rb, 0);
      2:  return encR(OR, rd, ra, rb, 0);
      3:  return encR(AND, rd, ra, rb, 0);
      4:  return encR(XOR, rd, ra, rb, 0);
      5:  return encR(SHIFT, rd, ra, 0, ($urandom % 2) ? 'h41 : 'h1);
      6:  return encI(ADD, rd, ra, $urandom);
      7:  return encI(RSUB, rd, ra, $urandom);
      8:  return encI(AND, rd, ra, $urandom);
      9:  return encI(LW, rd, 0, ($urandom % 16) * 4);  // Filled words only
      10: return encI(SW, rd, 0, ($urandom % 16) * 4);
      11: return encR(6'o77, rd, ra, rb, 0);  // Unknown
      12: return encI(SHIFT, rd, ra, $urandom);  // Not a real opcode
      13: return encI(OR, rd, ra, $urandom);
      default: return encI(XOR, rd, ra, $urandom);
    endcase
  endfunction

  task automatic issue(word_t w);
    instValid = 1'b1;
    instWord  = w;
    refExec(w);
    @(posedge gclk);
    #1;
    instValid = 1'b0;
  endtask

  task automatic bubble(int n);
    instValid = 1'b0;
    repeat (n) begin
      @(posedge gclk);
      #1;
    end
  endtask

  task automatic checkValue(string name, word_t expected, word_t actual);
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // Outputs are sampled mid-cycle once settled
  always @(negedge gclk) begin
    logic [36:0] e;
    if (!grst && wbValid) begin
      if (expQ.size() == 0) begin
        errors++;
        $display("Unexpected writeback to r%0d with nothing pending (%s)", wbReg, testName);
      end else begin
        e = expQ.pop_front();
        checkValue({testName, " reg"}, word_t'(e[36:32]), word_t'(wbReg));
        checkValue({testName, " data"}, e[31:0], wbData);
      end
    end
  end

  always @(posedge gclk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, errors so far %0d", CYCLE_LIMIT, errors);
      $display("Test failures found");
      $finish;
    end
  end

  initial begin
    int i;
    void'($urandom(32'h3cfa_5b35));
    grst      = 1'b1;
    instValid = 1'b0;
    instWord  = '0;
    for (i = 0; i < `AEXM_REG_COUNT; i++)
      modelRegs[i] = (i == 0) ? '0 : 'x;
    for (i = 0; i < (1 << `AEXM_DMEM_AW); i++)
      modelMem[i] = 'x;
    repeat (8) @(posedge gclk);
    #1;
    grst = 1'b0;

    testName = "regInit";
    for (i = 1; i < 32; i++)
      issue(encI(ADD, i, 0, $urandom));
    for (i = 1; i < 32; i++)
      issue(encR(ADD, i, i, 0, 0));  // Read back
    testName = "memInit";
    for (i = 0; i < 16; i++)
      issue(encI(SW, i % 7 + 1, 0, i * 4));

    testName = "aluChain";
    issue(encI(ADD, 1, 0, 100));
    issue(encI(ADD, 2, 1, -7));
    issue(encR(ADD, 3, 1, 2, 0));
    issue(encR(RSUB, 4, 3, 1, 0));
    issue(encR(OR, 5, 4, 3, 0));
    issue(encR(AND, 1, 5, 2, 0));
    issue(encR(XOR, 2, 1, 5, 0));
    issue(encI(ADD, 6, 0, -1000));
    issue(encR(SHIFT, 3, 6, 0, 'h1));   // sra of a negative value
    issue(encR(SHIFT, 4, 3, 0, 'h41));  // srl
    issue(encI(RSUB, 5, 4, 50));
    issue(encI(OR, 1, 5, 'h0f0f));
    issue(encI(AND, 2, 1, 'hff00));
    issue(encI(XOR, 3, 2, 'h5555));

    testName = "storeLoad";
    issue(encI(ADD, 6, 0, 'h1234));
    issue(encI(SW, 6, 0, 64));  // Store data just written
    issue(encI(LW, 7, 0, 64));
    issue(encR(ADD, 1, 7, 7, 0));  // Load used next
    issue(encI(ADD, 2, 0, 68));
    issue(encR(SW, 1, 0, 2, 0));
    issue(encR(LW, 3, 2, 0, 0));
    issue(encR(ADD, 4, 3, 2, 0));
    issue(encI(LW, 5, 0, 64));
    issue(encI(SW, 5, 0, 72));
    issue(encI(LW, 6, 0, 72));

    testName = "random";
    for (i = 0; i < NUM_RANDOM; i++) begin
      if ($urandom % 4 == 0)
        bubble(1 + $urandom % 2);
      issue(randomInst());
    end

    testName = "midReset";
    for (i = 0; i < 10; i++)
      issue(randomInst());
    // Writers that keep their own value, so dropped writebacks change no state
    for (i = 1; i < 4; i++)
      issue(encR(OR, i, i, 0, 0));
    // One reset edge with writers in flight and a word on the bus
    grst      = 1'b1;
    instValid = 1'b1;
    instWord  = encR(OR, 4, 4, 0, 0);
    expQ.delete();
    @(posedge gclk);
    #1;
    grst      = 1'b0;
    instValid = 1'b0;
    bubble(6);
    for (i = 0; i < 10; i++)
      issue(randomInst());
    bubble(10);

    if (expQ.size() != 0) begin
      errors++;
      $display("%0d expected writebacks never appeared", expQ.size());
    end
    $display("Errors: %0d", errors);
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

/* aexmLite.f */
+incdir+hw
hw/aexmPkg.sv
hw/aexmDecodeCtrl.sv
hw/aexmRegFile.sv
hw/aexmOperandStage.sv
hw/aexmExecStage.sv
hw/aexmDataMem.sv
hw/aexmCore.sv
testbench/aexmCoreTb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= aexmCoreTb
FILELIST  ?= aexmLite.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
